/* compile.f */
hdl/mem_stage_pkg.sv
hdl/wb_bus_if.sv
hdl/ex_mem_reg.sv
hdl/load_store_unit.sv
hdl/data_ram.sv
hdl/mem_wb_reg.sv
hdl/mem_stage_top.sv
sim/tb_clock_gen.sv
sim/tb_mem_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# verilator build and run of the memory stage testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_mem_stage -f compile.f \
    -o tb_mem_stage || exit 1
sim_out="$(./obj_dir/tb_mem_stage 2>&1)"
echo "$sim_out"
grep -q "^TESTBENCH PASSED$" <<< "$sim_out" && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

/* sim/tb_mem_stage.sv */
`timescale 1ns/1ps

module tb_mem_stage;
    import mem_stage_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int RAM_ADDR_BITS  = 10;
    localparam int RAM_WORDS      = 2 ** RAM_ADDR_BITS;
    localparam int NUM_ALU        = 12;
    localparam int NUM_PAIRS      = 4;
    localparam int NUM_LANE_WORDS = 4;
    localparam int NUM_BP_ITEMS   = 40;
    // each lane word takes a fill store, three lane stores and six loads
    localparam int TOTAL_ITEMS = 1 + NUM_ALU + 2 * NUM_PAIRS + 10 * NUM_LANE_WORDS + NUM_BP_ITEMS;
    localparam longint WATCHDOG_NS = longint'(TOTAL_ITEMS) * 200 * CLK_PERIOD;

    logic        I_sys_clk;
    logic        I_rst;
    logic        ex_valid;
    logic        ex_allowin;
    ex_mem_t     stim;
    logic        wb_valid;
    logic        wb_allowout = 1'b1;
    logic [63:0] wb_pc;
    logic        wb_reg_wen;
    logic [4:0]  wb_rd_addr;
    logic [63:0] wb_rd_data;

    mem_wb_t     expected_q[$];
    int          written_q[$];
    logic [63:0] ref_mem [RAM_WORDS];
    logic        bp_enable = 1'b0;
    int          stretch_left = 0;
    logic        held_valid = 1'b0;
    mem_wb_t     held_item;
    mem_wb_t     retire_item;
    int          full_stalls = 0;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) clk_gen_i (
        .clk (I_sys_clk),
        .rst (I_rst)
    );

    mem_stage_top #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) dut_i (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .ex_valid     (ex_valid),
        .ex_allowin   (ex_allowin),
        .ex_pc        (stim.pc),
        .ex_alu_out   (stim.alu_out),
        .ex_mem_addr  (stim.mem_addr),
        .ex_rs2_data  (stim.rs2_data),
        .ex_rstrb     (stim.rstrb),
        .ex_wstrb     (stim.wstrb),
        .ex_mem_wen   (stim.mem_wen),
        .ex_reg_wen   (stim.reg_wen),
        .ex_rd_addr   (stim.rd_addr),
        .ex_regin_sel (stim.regin_sel),
        .wb_valid     (wb_valid),
        .wb_allowout  (wb_allowout),
        .wb_pc        (wb_pc),
        .wb_reg_wen   (wb_reg_wen),
        .wb_rd_addr   (wb_rd_addr),
        .wb_rd_data   (wb_rd_data)
    );

    function automatic mem_wb_t wb_now();
        return '{pc: wb_pc, reg_wen: wb_reg_wen, rd_addr: wb_rd_addr, rd_data: wb_rd_data};
    endfunction

    function automatic logic [63:0] fill_word(input int wa);
        return {32'(wa) ^ 32'hc3a5_0f1e, ~32'(wa)};
    endfunction

    function automatic ex_mem_t base_item(input logic [2:0] sel, input logic wen);
        ex_mem_t item;
        item           = '0;
        item.pc        = {$urandom, $urandom} & ~64'd3;
        item.rd_addr   = 5'($urandom);
        item.reg_wen   = wen;
        item.regin_sel = sel;
        return item;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_wb(input mem_wb_t act, input mem_wb_t want, input string msg);
        if (act !== want) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                $time, msg, act, want));
        end
    endtask

    task automatic check_data(input logic [63:0] act, input logic [63:0] want, input string msg);
        if (act !== want) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                $time, msg, act, want));
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic issue_item(input ex_mem_t item, input mem_wb_t want);
        stim     = item;
        ex_valid = 1'b1;
        #1;
        while (!ex_allowin) begin
            @(negedge I_sys_clk);
            #1;
        end
        expected_q.push_back(want);
        @(negedge I_sys_clk);
        ex_valid = 1'b0;
    endtask

    task automatic send_alu(input logic use_pc4);
        ex_mem_t item;
        mem_wb_t want;
        item         = base_item(use_pc4 ? 3'b100 : 3'b001, 1'b1);
        item.alu_out = {$urandom, $urandom};
        want = '{pc: item.pc, reg_wen: 1'b1, rd_addr: item.rd_addr,
                 rd_data: use_pc4 ? item.pc + 64'd4 : item.alu_out};
        issue_item(item, want);
    endtask

    task automatic send_store(input int wa, input logic [63:0] data, input logic [7:0] lanes);
        ex_mem_t item;
        mem_wb_t want;
        item          = base_item(3'b001, 1'b0);
        item.mem_addr = 64'(wa) << 3;
        item.alu_out  = item.mem_addr;
        item.rs2_data = data;
        item.wstrb    = lanes;
        item.mem_wen  = 1'b1;
        want = '{pc: item.pc, reg_wen: 1'b0, rd_addr: item.rd_addr, rd_data: item.alu_out};
        for (int i = 0; i < 8; i++) begin
            if (lanes[i]) begin
                ref_mem[wa][8*i +: 8] = data[8*i +: 8];
            end
        end
        if (lanes == 8'hff) begin
            written_q.push_back(wa);
        end
        issue_item(item, want);
    endtask

    task automatic send_load(input int wa, input int offset, input int nbytes, input logic sign);
        ex_mem_t     item;
        mem_wb_t     want;
        logic [63:0] raw;
        logic [63:0] mask;
        item          = base_item(3'b010, 1'b1);
        item.mem_addr = (64'(wa) << 3) | 64'(offset);
        item.alu_out  = item.mem_addr;
        item.rstrb    = {sign, 8'(((1 << nbytes) - 1) << offset)};
        // expected value cut from the reference word
        raw  = ref_mem[wa] >> (8 * offset);
        mask = (nbytes == 8) ? '1 : (64'd1 << (8 * nbytes)) - 64'd1;
        want = '{pc: item.pc, reg_wen: 1'b1, rd_addr: item.rd_addr, rd_data: raw & mask};
        if (sign && raw[8*nbytes-1]) begin
            want.rd_data = want.rd_data | ~mask;
        end
        issue_item(item, want);
    endtask

    task automatic drain();
        while (expected_q.size() != 0) begin
            @(negedge I_sys_clk);
        end
        repeat (2) @(negedge I_sys_clk);
    endtask

    task automatic check_reset_state();
        @(negedge I_sys_clk);
        while (I_rst) begin
            @(negedge I_sys_clk);
        end
        #1;
        check_data(64'(wb_valid), 64'd0, "wb_valid after reset");
        check_data(64'(ex_allowin), 64'd1, "ex_allowin after reset");
    endtask

    task automatic test_alu_items();
        @(negedge I_sys_clk);
        send_alu(1'b0);
        #1;
        check_data(64'(wb_valid), 64'd0, "wb_valid one edge after acceptance");
        @(negedge I_sys_clk);
        #1;
        check_data(64'(wb_valid), 64'd1, "wb_valid two edges after acceptance");
        @(negedge I_sys_clk);
        for (int i = 0; i < NUM_ALU; i++) begin
            send_alu(1'($urandom_range(1, 0)));
        end
        drain();
    endtask

    task automatic test_store_load();
        int wa;
        @(negedge I_sys_clk);
        for (int i = 0; i < NUM_PAIRS; i++) begin
            wa = $urandom_range(RAM_WORDS - 1, 0);
            send_store(wa, {$urandom, $urandom}, 8'hff);
            send_load(wa, 0, 8, 1'b0);
        end
        drain();
    endtask

    task automatic test_byte_lanes();
        int wa;
        int nbytes;
        @(negedge I_sys_clk);
        for (int w = 0; w < NUM_LANE_WORDS; w++) begin
            wa = $urandom_range(RAM_WORDS - 1, 0);
            send_store(wa, fill_word(wa), 8'hff);
            repeat (3) send_store(wa, {$urandom, $urandom}, 8'($urandom));
            // byte, half and word, unsigned then signed
            for (int k = 0; k < 6; k++) begin
                nbytes = 1 << (k / 2);
                send_load(wa, nbytes * $urandom_range(8 / nbytes - 1, 0), nbytes, 1'(k % 2));
            end
        end
        drain();
    endtask

    task automatic test_backpressure();
        int stalls_before;
        int wa;
        int nbytes;
        stalls_before = full_stalls;
        bp_enable     = 1'b1;
        @(negedge I_sys_clk);
        for (int i = 0; i < NUM_BP_ITEMS; i++) begin
            wa     = written_q[$urandom_range(written_q.size() - 1, 0)];
            nbytes = 1 << $urandom_range(3, 0);
            case ($urandom_range(3, 0))
                0: send_alu(1'b0);
                1: send_alu(1'b1);
                2: send_store(wa, {$urandom, $urandom}, 8'($urandom));
                default: send_load(wa, nbytes * $urandom_range(8 / nbytes - 1, 0), nbytes,
                    1'($urandom_range(1, 0)));
            endcase
        end
        drain();
        bp_enable = 1'b0;
        check_data(64'(full_stalls > stalls_before), 64'd1, "ex_allowin low with stage full");
    endtask

    // random stall stretches on the writeback side
    always @(negedge I_sys_clk) begin
        if (!bp_enable) begin
            wb_allowout = 1'b1;
        end else if (stretch_left == 0) begin
            wb_allowout  = 1'($urandom_range(1, 0));
            stretch_left = $urandom_range(6, 1);
        end else begin
            stretch_left--;
        end
    end

    // scoreboard, sampled between edges
    always begin
        @(negedge I_sys_clk);
        #1;
        if (!I_rst) begin
            if (held_valid) begin
                check_data(64'(wb_valid), 64'd1, "wb_valid held under back-pressure");
                check_wb(wb_now(), held_item, "payload held under back-pressure");
            end
            if (wb_valid && !wb_allowout && !ex_allowin) begin
                full_stalls++;
            end
            held_valid = wb_valid && !wb_allowout;
            held_item  = wb_now();
            if (wb_valid && wb_allowout) begin
                if (expected_q.size() == 0) begin
                    abort_run("the writeback side produced an item that was never issued");
                end else begin
                    retire_item = expected_q.pop_front();
                    check_wb(wb_now(), retire_item, "retired item");
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("the pipeline hung, %0d items did not finish in time", TOTAL_ITEMS));
    end

    initial begin
        ex_valid = 1'b0;
        stim     = '0;
        void'($urandom(32'hfa23db70));
        check_reset_state();
        test_alu_items();
        test_store_load();
        test_byte_lanes();
        test_backpressure();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset covers the first rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* hdl/mem_stage_top.sv */
`timescale 1ns/1ps

module mem_stage_top #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic        I_sys_clk,
    input  logic        I_rst,
    input  logic        ex_valid,
    output logic        ex_allowin,
    input  logic [63:0] ex_pc,
    input  logic [63:0] ex_alu_out,
    input  logic [63:0] ex_mem_addr,
    input  logic [63:0] ex_rs2_data,
    input  logic [8:0]  ex_rstrb,
    input  logic [7:0]  ex_wstrb,
    input  logic        ex_mem_wen,
    input  logic        ex_reg_wen,
    input  logic [4:0]  ex_rd_addr,
    input  logic [2:0]  ex_regin_sel,
    output logic        wb_valid,
    input  logic        wb_allowout,
    output logic [63:0] wb_pc,
    output logic        wb_reg_wen,
    output logic [4:0]  wb_rd_addr,
    output logic [63:0] wb_rd_data
);
    import mem_stage_pkg::*;

    ex_mem_t     ex_in;
    ex_mem_t     mem_item;
    mem_wb_t     wb_item;
    logic        mem_valid;
    logic        wb_allowin;
    logic        mem_start;
    logic        item_taken;
    logic        mem_done;
    logic [63:0] load_data;

    assign ex_in = '{
        pc:        ex_pc,
        alu_out:   ex_alu_out,
        mem_addr:  ex_mem_addr,
        rs2_data:  ex_rs2_data,
        rstrb:     ex_rstrb,
        wstrb:     ex_wstrb,
        mem_wen:   ex_mem_wen,
        reg_wen:   ex_reg_wen,
        rd_addr:   ex_rd_addr,
        regin_sel: ex_regin_sel
    };

    wb_bus_if #(.ADR_BITS(RAM_ADDR_BITS)) dbus ();

    ex_mem_reg ex_mem_reg_i (
        .I_sys_clk   (I_sys_clk),
        .I_rst       (I_rst),
        .in_valid    (ex_valid),
        .in_data     (ex_in),
        .in_allowin  (ex_allowin),
        .out_allowin (wb_allowin),
        .mem_done    (mem_done),
        .out_valid   (mem_valid),
        .out_data    (mem_item),
        .mem_start   (mem_start),
        .item_taken  (item_taken)
    );

    load_store_unit #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) lsu_i (
        .I_sys_clk  (I_sys_clk),
        .I_rst      (I_rst),
        .mem_start  (mem_start),
        .item_taken (item_taken),
        .req        (mem_item),
        .bus        (dbus.master),
        .mem_done   (mem_done),
        .load_data  (load_data)
    );

    data_ram #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) data_ram_i (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .bus       (dbus.slave)
    );

    mem_wb_reg mem_wb_reg_i (
        .I_sys_clk   (I_sys_clk),
        .I_rst       (I_rst),
        .in_valid    (mem_valid),
        .in_data     (mem_item),
        .load_data   (load_data),
        .in_allowin  (wb_allowin),
        .out_allowin (wb_allowout),
        .out_valid   (wb_valid),
        .out_data    (wb_item)
    );

    assign wb_pc      = wb_item.pc;
    assign wb_reg_wen = wb_item.reg_wen;
    assign wb_rd_addr = wb_item.rd_addr;
    assign wb_rd_data = wb_item.rd_data;

endmodule

/* hdl/mem_wb_reg.sv */
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                   I_sys_clk,
    input  logic                   I_rst,
    input  logic                   in_valid,
    input  mem_stage_pkg::ex_mem_t in_data,
    input  logic [63:0]            load_data,
    output logic                   in_allowin,
    input  logic                   out_allowin,
    output logic                   out_valid,
    output mem_stage_pkg::mem_wb_t out_data
);
    import mem_stage_pkg::*;

    logic        valid_q;
    logic [63:0] wb_value;

    assign in_allowin = !valid_q || out_allowin;
    assign out_valid  = valid_q;

    // writeback source mux
    always_comb begin
        case (1'b1)
            in_data.regin_sel[SEL_LOAD]: wb_value = load_data;
            in_data.regin_sel[SEL_PC4]:  wb_value = in_data.pc + 64'd4;
            in_data.regin_sel[SEL_ALU]:  wb_value = in_data.alu_out;
            default:                     wb_value = in_data.alu_out;
        endcase
    end

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            valid_q <= 1'b0;
        end else if (in_allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (in_valid && in_allowin) begin
            out_data.pc      <= in_data.pc;
            out_data.reg_wen <= in_data.reg_wen;
            out_data.rd_addr <= in_data.rd_addr;
            out_data.rd_data <= wb_value;
        end
    end

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic     I_sys_clk,
    input  logic     I_rst,
    wb_bus_if.slave  bus
);
    localparam int DEPTH = 2 ** RAM_ADDR_BITS;

    logic [63:0] mem [DEPTH];
    logic        req_new;

    // first cycle of a strobe, ack not yet given
    assign req_new = bus.cyc && bus.stb && !bus.ack;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req_new;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (req_new) begin
            if (bus.we) begin
                for (int i = 0; i < 8; i++) begin
                    if (bus.sel[i]) begin
                        mem[bus.adr][8*i +: 8] <= bus.dat_w[8*i +: 8];
                    end
                end
            end
            // read word returned alongside ack
            bus.dat_r <= mem[bus.adr];
        end
    end

    a_ack_in_cyc: assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        bus.ack |-> bus.cyc
    );

endmodule

/* hdl/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic                   I_sys_clk,
    input  logic                   I_rst,
    input  logic                   mem_start,
    input  logic                   item_taken,
    input  mem_stage_pkg::ex_mem_t req,
    wb_bus_if.master               bus,
    output logic                   mem_done,
    output logic [63:0]            load_data
);
    import mem_stage_pkg::*;

    logic active;
    logic bus_done;

    // move the lowest read lane to bit 0, then trim and extend
    function automatic logic [63:0] format_load(input logic [63:0] word, input rstrb_t strb);
        logic [63:0] shifted;
        logic [2:0]  lane;
        logic [3:0]  nbytes;
        logic        sign;
        logic [63:0] result;
        lane   = 3'd0;
        nbytes = 4'd0;
        for (int i = 7; i >= 0; i--) begin
            if (strb[i]) begin
                lane = 3'(i);
            end
        end
        for (int i = 0; i < 8; i++) begin
            nbytes = nbytes + {3'b000, strb[i]};
        end
        shifted = word >> {lane, 3'b000};
        sign    = strb[RSTRB_SIGN];
        case (nbytes)
            4'd1:    result = {{56{sign & shifted[7]}}, shifted[7:0]};
            4'd2:    result = {{48{sign & shifted[15]}}, shifted[15:0]};
            4'd4:    result = {{32{sign & shifted[31]}}, shifted[31:0]};
            default: result = shifted;
        endcase
        return result;
    endfunction

    assign bus.cyc  = active;
    assign bus.stb  = active;
    assign bus_done = active && bus.ack;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            active   <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            if (mem_start) begin
                active <= 1'b1;
            end else if (bus_done) begin
                active <= 1'b0;
            end
            // done stays up until the stage register hands the item on
            if (item_taken) begin
                mem_done <= 1'b0;
            end else if (bus_done) begin
                mem_done <= 1'b1;
            end
        end
    end

    // request fields are captured once and held for the whole cycle
    always_ff @(posedge I_sys_clk) begin
        if (mem_start) begin
            bus.we    <= req.mem_wen;
            bus.adr   <= req.mem_addr[RAM_ADDR_BITS+2:3];
            bus.sel   <= req.mem_wen ? req.wstrb : req.rstrb[7:0];
            bus.dat_w <= req.rs2_data;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (bus_done) begin
            load_data <= format_load(bus.dat_r, req.rstrb);
        end
    end

    // classic cycle, request frozen until the slave answers
    a_req_stable: assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        bus.stb && !bus.ack |=> bus.stb && $stable(bus.adr) && $stable(bus.we)
            && $stable(bus.sel) && $stable(bus.dat_w)
    );

endmodule

/* hdl/ex_mem_reg.sv */
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                   I_sys_clk,
    input  logic                   I_rst,
    input  logic                   in_valid,
    input  mem_stage_pkg::ex_mem_t in_data,
    output logic                   in_allowin,
    input  logic                   out_allowin,
    input  logic                   mem_done,
    output logic                   out_valid,
    output mem_stage_pkg::ex_mem_t out_data,
    output logic                   mem_start,
    output logic                   item_taken
);
    import mem_stage_pkg::*;

    logic input_valid;
    logic item_done;
    logic accept;

    assign accept = in_valid && in_allowin;

    // a held load or store waits for the data access to finish
    assign item_done  = is_mem_access(out_data) ? mem_done : 1'b1;
    assign out_valid  = input_valid && item_done;
    assign in_allowin = !input_valid || (item_done && out_allowin);
    assign item_taken = out_valid && out_allowin;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            input_valid <= 1'b0;
        end else if (in_allowin) begin
            input_valid <= in_valid;
        end
    end

    // single-cycle kick to the load/store unit after a memory item lands
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            mem_start <= 1'b0;
        end else begin
            mem_start <= accept && is_mem_access(in_data);
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (accept) begin
            out_data <= in_data;
        end
    end

    // the previous access is retired before a new one starts
    a_start_idle: assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        mem_start |-> !mem_done
    );

endmodule

/* hdl/wb_bus_if.sv */
`timescale 1ns/1ps

interface wb_bus_if #(
    parameter int ADR_BITS = 10
);
    logic                cyc;
    logic                stb;
    logic                we;
    logic [ADR_BITS-1:0] adr;
    logic [7:0]          sel;
    logic [63:0]         dat_w;
    logic [63:0]         dat_r;
    logic                ack;

    // load/store unit side
    modport master (
        output cyc, stb, we, adr, sel, dat_w,
        input  dat_r, ack
    );

    // memory side
    modport slave (
        input  cyc, stb, we, adr, sel, dat_w,
        output dat_r, ack
    );

endinterface

/* hdl/mem_stage_pkg.sv */
package mem_stage_pkg;

    // one-hot writeback source, the load bit also marks a load
    typedef logic [2:0] regin_sel_t;

    // byte lanes in [7:0], sign extension request in [8]
    typedef logic [8:0] rstrb_t;

    // byte-lane write enables, sent as the wishbone select
    typedef logic [7:0] wstrb_t;

    localparam int SEL_ALU  = 0;
    localparam int SEL_LOAD = 1;
    localparam int SEL_PC4  = 2;

    localparam int RSTRB_SIGN = 8;

    typedef struct packed {
        logic [63:0] pc;
        logic [63:0] alu_out;
        logic [63:0] mem_addr;
        logic [63:0] rs2_data;
        rstrb_t      rstrb;
        wstrb_t      wstrb;
        logic        mem_wen;
        logic        reg_wen;
        logic [4:0]  rd_addr;
        regin_sel_t  regin_sel;
    } ex_mem_t;

    typedef struct packed {
        logic [63:0] pc;
        logic        reg_wen;
        logic [4:0]  rd_addr;
        logic [63:0] rd_data;
    } mem_wb_t;

    // loads and stores need a data access, everything else passes through
    function automatic logic is_mem_access(input ex_mem_t item);
        return item.regin_sel[SEL_LOAD] || item.mem_wen;
    endfunction

endpackage
